// ==== logic/isaPkg.sv ====
// ------------------------------------------------------------------------
// ISA definitions for the execute stage
// datapath width, shift amount width
// ALU opcode, branch condition and forwarding source encodings
// ------------------------------------------------------------------------
`default_nettype none

package isaPkg;

   // one machine word
   localparam int dataW = 16;
   // bits needed to hold a shift or rotate amount
   localparam int shiftW = $clog2(dataW);

   // ALU operations, low nibble of the decoded opcode
   typedef enum logic [3:0] {
      aluRll = 4'd0,
      aluSll = 4'd1,
      aluRor = 4'd2,
      aluSra = 4'd3,
      aluAdd = 4'd4,
      aluOr  = 4'd5,
      aluXor = 4'd6,
      aluAnd = 4'd7,
      aluBtr = 4'd8
   } aluOpT;

   // branch and set-on-compare conditions
   // seq/slt/sle/sco share the flag logic of the branches
   // needs a 4th bit, nine conditions in all
   typedef enum logic [3:0] {
      brNone = 4'd0,
      brEqz  = 4'd1,
      brNez  = 4'd2,
      brLtz  = 4'd3,
      brGez  = 4'd4,
      brSeq  = 4'd5,
      brSlt  = 4'd6,
      brSle  = 4'd7,
      brSco  = 4'd8
   } brCondT;

   // where an operand comes from
   // ex* taps the EX/MEM register, mem* the memory stage bus
   typedef enum logic [2:0] {
      fwdNone, fwdExAlu, fwdExImm, fwdExLink,
      fwdMemAlu, fwdMemImm, fwdMemLink, fwdMemLoad
   } fwdSrcT;

endpackage

`default_nettype wire

// ==== logic/pipePkg.sv ====
// ------------------------------------------------------------------------
// pipeline records around the execute stage
// ID/EX control word, MEM forwarding bus, EX/MEM register contents
// ------------------------------------------------------------------------
`default_nettype none

package pipePkg;

   // decoded control from ID/EX
   typedef struct packed {
      // ALU setup
      isaPkg::aluOpT  aluOp;
      logic           invA;
      logic           invB;
      logic           cin;
      // branch or set condition
      isaPkg::brCondT brCond;
      // imm11 instead of imm8 in the target adder
      logic           immLong;
      // target base is the ALU result, not incPC (JR/JALR)
      logic           aluBase;
      // next PC straight from the ALU
      logic           aluJump;
      // link value is incPC (JAL/JALR)
      logic           linkSel;
      // result is the condition flag
      logic           setOp;
      // next PC forced to incPC
      logic           slbi;
      // inB holds an immediate, never forwarded
      logic           bIsImm;
      // instruction reads data memory
      logic           isLoad;
   } exCtrlT;

   // values offered back by the memory stage
   typedef struct packed {
      logic [isaPkg::dataW-1:0] aluRes;
      logic [isaPkg::dataW-1:0] imm8;
      logic [isaPkg::dataW-1:0] link;
      // data read by a load in MEM
      logic [isaPkg::dataW-1:0] loadData;
   } memFwdT;

   // EX/MEM register
   typedef struct packed {
      // ALU result or set flag
      logic [isaPkg::dataW-1:0] result;
      logic [isaPkg::dataW-1:0] link;
      logic [isaPkg::dataW-1:0] imm8;
      // already forwarded store value
      logic [isaPkg::dataW-1:0] storeData;
      logic                     isLoad;
   } exMemT;

endpackage

`default_nettype wire

// ==== logic/operandForward.sv ====
// ------------------------------------------------------------------------
// operand forwarding muxes
// A operand, B operand and store data, each with its own source select
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module operandForward (
   input  isaPkg::fwdSrcT              fwdA,
   input  isaPkg::fwdSrcT              fwdB,
   input  isaPkg::fwdSrcT              fwdStore,
   input  logic [isaPkg::dataW-1:0]    inA,
   input  logic [isaPkg::dataW-1:0]    inB,
   input  logic [isaPkg::dataW-1:0]    storeIn,
   input  logic                        bIsImm,
   input  pipePkg::exMemT              exFwd,
   input  pipePkg::memFwdT             memFwd,
   output logic [isaPkg::dataW-1:0]    opA,
   output logic [isaPkg::dataW-1:0]    opB,
   output logic [isaPkg::dataW-1:0]    storeData
);

   // one select decoder shared by all three operands
   function automatic logic [isaPkg::dataW-1:0] pick(
      input isaPkg::fwdSrcT           src,
      input logic [isaPkg::dataW-1:0] orig
   );
      logic [isaPkg::dataW-1:0] val;
      case (src)
         // EX to EX, from the stage's own register
         isaPkg::fwdExAlu:   val = exFwd.result;
         isaPkg::fwdExImm:   val = exFwd.imm8;
         isaPkg::fwdExLink:  val = exFwd.link;
         // MEM to EX, from the memory stage bus
         isaPkg::fwdMemAlu:  val = memFwd.aluRes;
         isaPkg::fwdMemImm:  val = memFwd.imm8;
         isaPkg::fwdMemLink: val = memFwd.link;
         isaPkg::fwdMemLoad: val = memFwd.loadData;
         // no hazard, register file value
         default:            val = orig;
      endcase
      return val;
   endfunction

   logic [isaPkg::dataW-1:0] fwdBVal;

   always_comb begin
      opA     = pick(fwdA, inA);
      fwdBVal = pick(fwdB, inB);
      // an immediate in inB wins over any forward request
      if (bIsImm) begin
         opB = inB;
      end else begin
         opB = fwdBVal;
      end
      // store value has its own select
      // lets a store pick up a load result sitting in MEM
      storeData = pick(fwdStore, storeIn);
   end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// ------------------------------------------------------------------------
// 16-bit ALU
// optional operand inversion and carry-in
// rotates, shifts, add, logic ops, bit reverse
// zero/sign/overflow/carry flags from the adder
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module alu (
   input  logic [isaPkg::dataW-1:0] a,
   input  logic [isaPkg::dataW-1:0] b,
   input  isaPkg::aluOpT            op,
   input  logic                     invA,
   input  logic                     invB,
   input  logic                     cin,
   output logic [isaPkg::dataW-1:0] result,
   output logic                     zero,
   output logic                     sign,
   output logic                     ofl,
   output logic                     carry
);

   localparam int msb = isaPkg::dataW - 1;

   logic [isaPkg::dataW-1:0]   aIn;
   logic [isaPkg::dataW-1:0]   bIn;
   // one extra bit for the carry out
   logic [isaPkg::dataW:0]     sum;
   logic [isaPkg::shiftW-1:0]  amt;
   // doubled word, rotates fall out of a plain shift
   logic [2*isaPkg::dataW-1:0] dblL;
   logic [2*isaPkg::dataW-1:0] dblR;
   logic [isaPkg::dataW-1:0]   rev;

   // operand conditioning, subtract is ~x + 1 via invX and cin
   assign aIn = invA ? ~a : a;
   assign bIn = invB ? ~b : b;

   assign sum = {1'b0, aIn} + {1'b0, bIn} + {{isaPkg::dataW{1'b0}}, cin};

   // shift amount from the low bits of B
   assign amt = bIn[isaPkg::shiftW-1:0];

   assign dblL = {aIn, aIn} << amt;
   assign dblR = {aIn, aIn} >> amt;

   // bit reverse of A
   always_comb begin
      for (int i = 0; i < isaPkg::dataW; i++) begin
         rev[i] = aIn[msb-i];
      end
   end

   always_comb begin
      case (op)
         // upper half of the doubled word after a left shift
         isaPkg::aluRll: result = dblL[2*isaPkg::dataW-1:isaPkg::dataW];
         isaPkg::aluSll: result = aIn << amt;
         // lower half after a right shift
         isaPkg::aluRor: result = dblR[isaPkg::dataW-1:0];
         isaPkg::aluSra: result = $signed(aIn) >>> amt;
         isaPkg::aluAdd: result = sum[msb:0];
         isaPkg::aluOr:  result = aIn | bIn;
         isaPkg::aluXor: result = aIn ^ bIn;
         isaPkg::aluAnd: result = aIn & bIn;
         isaPkg::aluBtr: result = rev;
         default:        result = '0;
      endcase
   end

   // flags always track the adder, whatever op is selected
   // so compares by subtraction work from any opcode setup
   assign carry = sum[isaPkg::dataW];
   assign sign  = sum[msb];
   assign zero  = (sum[msb:0] == '0);
   // overflow: like-signed inputs, sum sign differs
   assign ofl   = (aIn[msb] == bIn[msb]) && (sum[msb] != aIn[msb]);

endmodule

`default_nettype wire

// ==== logic/branchCond.sv ====
// ------------------------------------------------------------------------
// branch and set-on-compare condition
// maps a condition code onto the ALU adder flags
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module branchCond (
   input  isaPkg::brCondT cond,
   input  logic           zero,
   input  logic           sign,
   input  logic           ofl,
   input  logic           carry,
   output logic           taken
);

   // signed less-than after a subtract
   logic lessThan;

   assign lessThan = sign ^ ofl;

   always_comb begin
      case (cond)
         // equality, branch form and set form
         isaPkg::brEqz,
         isaPkg::brSeq: taken = zero;
         isaPkg::brNez: taken = ~zero;
         // sign tests against zero
         isaPkg::brLtz: taken = sign;
         isaPkg::brGez: taken = ~sign;
         isaPkg::brSlt: taken = lessThan;
         isaPkg::brSle: taken = lessThan | zero;
         // carry out of the add
         isaPkg::brSco: taken = carry;
         // brNone and unused codes
         default:       taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/pcTarget.sv ====
// ------------------------------------------------------------------------
// branch target adder
// next-PC selection and link value
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module pcTarget (
   input  logic [isaPkg::dataW-1:0] incPC,
   input  logic [isaPkg::dataW-1:0] aluRes,
   input  logic [isaPkg::dataW-1:0] imm8,
   input  logic [isaPkg::dataW-1:0] imm11,
   input  pipePkg::exCtrlT          ctrl,
   input  logic                     taken,
   output logic [isaPkg::dataW-1:0] newPC,
   output logic [isaPkg::dataW-1:0] link
);

   logic [isaPkg::dataW-1:0] base;
   logic [isaPkg::dataW-1:0] offset;
   logic [isaPkg::dataW-1:0] target;
   logic [isaPkg::dataW-1:0] brTarget;

   // PC-relative unless the register form asks for the ALU value
   assign base   = ctrl.aluBase ? aluRes : incPC;
   // imm11 for jumps, imm8 for branches
   assign offset = ctrl.immLong ? imm11 : imm8;

   // both immediates arrive already sign-extended
   // carry out of the target add is dropped
   assign target = base + offset;

   // fall through when the condition fails
   assign brTarget = taken ? target : incPC;

   // JAL/JALR save the return address
   assign link = ctrl.linkSel ? incPC : brTarget;

   always_comb begin
      if (ctrl.slbi) begin
         // SLBI never redirects
         newPC = incPC;
      end else if (ctrl.aluJump) begin
         newPC = aluRes;
      end else begin
         newPC = brTarget;
      end
   end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
// ------------------------------------------------------------------------
// execute stage top
// forwarding, ALU, branch condition and target logic
// EX/MEM register with stall hold, fed back as the EX forward source
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module executeStage (
   input  logic                     clk,
   input  logic                     arstN,
   input  logic                     exValid,
   input  logic                     stall,
   input  pipePkg::exCtrlT          ctrl,
   input  logic [isaPkg::dataW-1:0] inA,
   input  logic [isaPkg::dataW-1:0] inB,
   input  logic [isaPkg::dataW-1:0] storeIn,
   input  logic [isaPkg::dataW-1:0] incPC,
   input  logic [isaPkg::dataW-1:0] imm8,
   input  logic [isaPkg::dataW-1:0] imm11,
   input  isaPkg::fwdSrcT           fwdA,
   input  isaPkg::fwdSrcT           fwdB,
   input  isaPkg::fwdSrcT           fwdStore,
   input  pipePkg::memFwdT          memFwd,
   output logic [isaPkg::dataW-1:0] newPC,
   output logic                     branchTaken,
   output pipePkg::exMemT           exMem,
   output logic                     memValid
);

   logic [isaPkg::dataW-1:0] opA;
   logic [isaPkg::dataW-1:0] opB;
   logic [isaPkg::dataW-1:0] storeData;
   logic [isaPkg::dataW-1:0] aluRes;
   logic [isaPkg::dataW-1:0] linkVal;
   logic                     zero;
   logic                     sign;
   logic                     ofl;
   logic                     carry;
   pipePkg::exMemT           nextMem;

   // EX-side sources come back from our own register
   operandForward forwardUnit (
      .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore),
      .inA(inA), .inB(inB), .storeIn(storeIn),
      .bIsImm(ctrl.bIsImm), .exFwd(exMem), .memFwd(memFwd),
      .opA(opA), .opB(opB), .storeData(storeData)
   );

   alu aluUnit (
      .a(opA), .b(opB), .op(ctrl.aluOp),
      .invA(ctrl.invA), .invB(ctrl.invB), .cin(ctrl.cin),
      .result(aluRes), .zero(zero), .sign(sign), .ofl(ofl), .carry(carry)
   );

   branchCond condUnit (
      .cond(ctrl.brCond), .zero(zero), .sign(sign), .ofl(ofl), .carry(carry),
      .taken(branchTaken)
   );

   // newPC goes straight out to fetch, no register
   pcTarget targetUnit (
      .incPC(incPC), .aluRes(aluRes), .imm8(imm8), .imm11(imm11),
      .ctrl(ctrl), .taken(branchTaken), .newPC(newPC), .link(linkVal)
   );

   // stage record, set ops write the flag as 0/1
   always_comb begin
      nextMem.result    = ctrl.setOp ? {{(isaPkg::dataW-1){1'b0}}, branchTaken} : aluRes;
      nextMem.link      = linkVal;
      nextMem.imm8      = imm8;
      nextMem.storeData = storeData;
      nextMem.isLoad    = ctrl.isLoad;
   end

   // EX/MEM register, one cycle latency, frozen while stall is high
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exMem    <= '0;
         memValid <= 1'b0;
      end else if (!stall) begin
         exMem    <= nextMem;
         memValid <= exValid;
      end
   end

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
// ------------------------------------------------------------------------
// testbench clock and reset
// 4 ns clock, active-low reset held for 10 cycles
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module tbClock (
   output logic clk,
   output logic arstN
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // release on a falling edge, away from the register edge
   initial begin
      arstN = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/executeStage_sva.sv ====
// ------------------------------------------------------------------------
// concurrent checks on the EX/MEM register
// reset value, stall hold, valid pipelining
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module executeStage_sva (
   input logic           clk,
   input logic           arstN,
   input logic           exValid,
   input logic           stall,
   input pipePkg::exMemT exMem,
   input logic           memValid
);

   // nothing valid leaves EX while reset is held
   resetLow: assert property (@(posedge clk) !arstN |-> !memValid)
      else $error("memValid high during reset");

   // register frozen for the whole stall
   stallHold: assert property (@(posedge clk) disable iff (!arstN)
      stall |=> $stable(exMem))
      else $error("exMem changed under stall");

   // one cycle of latency on the valid bit
   validFollow: assert property (@(posedge clk) disable iff (!arstN)
      !stall |=> (memValid == $past(exValid)))
      else $error("memValid did not follow exValid");

endmodule

`default_nettype wire

// ==== tests/executeStage_tb.sv ====
// ------------------------------------------------------------------------
// directed tests for the execute stage
// reference model of ALU, flags, conditions and next PC
// cycle limit and result reporting
// ------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module executeStage_tb;

   // cycles per test in order reset, alu, branch, forward, pc, stall
   localparam int testLen = 10 + 36 + 54 + 5 + 6 + 5;
   localparam int cycleLimit = 2 * testLen;

   logic clk;
   logic arstN;
   logic exValid;
   logic stall;
   pipePkg::exCtrlT ctrl;
   logic [15:0] inA, inB, storeIn, incPC, imm8, imm11;
   isaPkg::fwdSrcT fwdA, fwdB, fwdStore;
   pipePkg::memFwdT memFwd;
   logic [15:0] newPC;
   logic branchTaken;
   pipePkg::exMemT exMem;
   logic memValid;

   integer seed = 32'h3107;
   int cycles = 0;
   int checkCount = 0;
   int errCount = 0;
   int testCount = 0;

   tbClock clkGen (.clk(clk), .arstN(arstN));

   executeStage DUT (
      .clk(clk), .arstN(arstN), .exValid(exValid), .stall(stall), .ctrl(ctrl),
      .inA(inA), .inB(inB), .storeIn(storeIn), .incPC(incPC), .imm8(imm8),
      .imm11(imm11), .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore),
      .memFwd(memFwd), .newPC(newPC), .branchTaken(branchTaken),
      .exMem(exMem), .memValid(memValid)
   );

   bind executeStage executeStage_sva regChecks (
      .clk(clk), .arstN(arstN), .exValid(exValid), .stall(stall),
      .exMem(exMem), .memValid(memValid)
   );

   // hard stop if a wait never returns
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("timeout: run exceeded %0d cycles", cycleLimit);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ALU reference with rotates built from two shifts
   function automatic logic [15:0] aluModel(input isaPkg::aluOpT op,
         input logic [15:0] a, input logic [15:0] b,
         input logic ia, input logic ib, input logic ci);
      logic [15:0] x, y, r;
      int s;
      x = ia ? ~a : a;
      y = ib ? ~b : b;
      s = y[3:0];
      r = '0;
      case (op)
         isaPkg::aluRll: r = (x << s) | (s == 0 ? 16'h0 : x >> (16 - s));
         isaPkg::aluSll: r = x << s;
         isaPkg::aluRor: r = (x >> s) | (s == 0 ? 16'h0 : x << (16 - s));
         isaPkg::aluSra: begin
            r = x;
            for (int k = 0; k < s; k++) r = {r[15], r[15:1]};
         end
         isaPkg::aluAdd: r = x + y + ci;
         isaPkg::aluOr:  r = x | y;
         isaPkg::aluXor: r = x ^ y;
         isaPkg::aluAnd: r = x & y;
         isaPkg::aluBtr: for (int k = 0; k < 16; k++) r[k] = x[15 - k];
         default:        r = '0;
      endcase
      return r;
   endfunction

   // condition from the adder flags with overflow by signed range
   function automatic logic takenModel(input isaPkg::brCondT c,
         input logic [15:0] a, input logic [15:0] b,
         input logic ia, input logic ib, input logic ci);
      logic [15:0] x, y;
      int full, sx, sy, sc;
      logic z, sg, ov, cy;
      x = ia ? ~a : a;
      y = ib ? ~b : b;
      full = x + y + ci;
      sx = $signed(x);
      sy = $signed(y);
      sc = ci;
      z = (full[15:0] == 16'h0);
      sg = full[15];
      cy = full[16];
      ov = (sx + sy + sc > 32767) || (sx + sy + sc < -32768);
      case (c)
         isaPkg::brEqz, isaPkg::brSeq: return z;
         isaPkg::brNez: return !z;
         isaPkg::brLtz: return sg;
         isaPkg::brGez: return !sg;
         isaPkg::brSlt: return sg ^ ov;
         isaPkg::brSle: return (sg ^ ov) | z;
         isaPkg::brSco: return cy;
         default:       return 1'b0;
      endcase
   endfunction

   task automatic checkVal(input string name, input logic [15:0] got,
         input logic [15:0] exp);
      checkCount++;
      assert (got === exp) else begin
         $display("error %s got %h expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic reportTest(input string name, input int errBefore);
      testCount++;
      $display("%s finished with %0d errors", name, errCount - errBefore);
   endtask

   task automatic setDefaults();
      ctrl = '0;
      {inA, inB, storeIn, incPC, imm8, imm11} = '0;
      fwdA = isaPkg::fwdNone;
      fwdB = isaPkg::fwdNone;
      fwdStore = isaPkg::fwdNone;
      memFwd = '0;
      exValid = 1'b1;
      stall = 1'b0;
   endtask

   // just past the rising edge where register outputs have settled
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic resetTest();
      int e;
      e = errCount;
      checkVal("memValid", {15'h0, memValid}, 16'h0);
      checkVal("exMem.result", exMem.result, 16'h0);
      checkVal("exMem.storeData", exMem.storeData, 16'h0);
      reportTest("reset", e);
   endtask

   task automatic aluTest();
      int e;
      logic [15:0] a, b;
      e = errCount;
      for (int op = 0; op < 9; op++) begin
         for (int rep = 0; rep < 4; rep++) begin
            @(negedge clk);
            setDefaults();
            a = $random(seed);
            b = $random(seed);
            ctrl.aluOp = isaPkg::aluOpT'(op);
            ctrl.invA = (rep == 1);
            ctrl.invB = (rep >= 2);
            ctrl.cin = (rep == 3);
            inA = a;
            inB = b;
            tick();
            checkVal("exMem.result", exMem.result, aluModel(isaPkg::aluOpT'(op),
               a, b, rep == 1, rep >= 2, rep == 3));
         end
      end
      reportTest("alu", e);
   endtask

   task automatic branchTest();
      int e;
      logic t;
      logic [15:0] pa [6] = '{16'd5, 16'd3, 16'd7, 16'h8000, 16'h7fff, 16'h0};
      logic [15:0] pb [6] = '{16'd5, 16'd7, 16'd3, 16'h0001, 16'hffff, 16'h0};
      e = errCount;
      for (int c = 0; c < 9; c++) begin
         for (int p = 0; p < 6; p++) begin
            @(negedge clk);
            setDefaults();
            // a - b through inverted B and carry in
            ctrl.aluOp = isaPkg::aluAdd;
            ctrl.invB = 1'b1;
            ctrl.cin = 1'b1;
            ctrl.setOp = 1'b1;
            ctrl.brCond = isaPkg::brCondT'(c);
            inA = pa[p];
            inB = pb[p];
            t = takenModel(isaPkg::brCondT'(c), pa[p], pb[p], 1'b0, 1'b1, 1'b1);
            #1;
            checkVal("branchTaken", {15'h0, branchTaken}, {15'h0, t});
            tick();
            checkVal("exMem.result", exMem.result, {15'h0, t});
         end
      end
      reportTest("branch", e);
   endtask

   task automatic forwardTest();
      int e;
      e = errCount;
      // producer whose fields feed the next two instructions
      @(negedge clk);
      setDefaults();
      ctrl.aluOp = isaPkg::aluAdd;
      inA = 16'd100;
      inB = 16'd23;
      imm8 = 16'h0042;
      incPC = 16'h0300;
      tick();
      // dependent right behind it with stale register file values
      @(negedge clk);
      fwdA = isaPkg::fwdExAlu;
      fwdB = isaPkg::fwdExImm;
      inA = 16'hdead;
      inB = 16'hbeef;
      tick();
      checkVal("exMem.result", exMem.result, 16'd123 + 16'h0042);
      @(negedge clk);
      fwdA = isaPkg::fwdExLink;
      fwdB = isaPkg::fwdNone;
      inB = 16'h0001;
      tick();
      checkVal("exMem.result", exMem.result, 16'h0301);
      // MEM side sources and a load result into store data
      @(negedge clk);
      memFwd.aluRes = 16'h1000;
      memFwd.imm8 = 16'h0011;
      memFwd.link = 16'h2000;
      memFwd.loadData = 16'h5a5a;
      fwdA = isaPkg::fwdMemAlu;
      fwdB = isaPkg::fwdMemImm;
      fwdStore = isaPkg::fwdMemLoad;
      tick();
      checkVal("exMem.result", exMem.result, 16'h1011);
      checkVal("exMem.storeData", exMem.storeData, 16'h5a5a);
      // immediate B must ignore fwdB
      @(negedge clk);
      ctrl.bIsImm = 1'b1;
      fwdA = isaPkg::fwdMemLink;
      fwdB = isaPkg::fwdMemAlu;
      fwdStore = isaPkg::fwdNone;
      inB = 16'h0005;
      storeIn = 16'h0777;
      tick();
      checkVal("exMem.result", exMem.result, 16'h2005);
      checkVal("exMem.storeData", exMem.storeData, 16'h0777);
      reportTest("forward", e);
   endtask

   // next PC and link from the target rules
   task automatic pcCase(input logic [15:0] a, input isaPkg::brCondT c,
         input logic base, input logic jump, input logic lsel, input logic lng,
         input logic sl);
      logic t;
      logic [15:0] alu, tgt, br, expPC, expLink;
      @(negedge clk);
      setDefaults();
      ctrl.aluOp = isaPkg::aluAdd;
      ctrl.brCond = c;
      ctrl.aluBase = base;
      ctrl.aluJump = jump;
      ctrl.linkSel = lsel;
      ctrl.immLong = lng;
      ctrl.slbi = sl;
      inA = a;
      incPC = 16'h0100;
      imm8 = 16'hfff0;
      imm11 = 16'h0200;
      alu = a;
      t = takenModel(c, a, 16'h0, 1'b0, 1'b0, 1'b0);
      tgt = (base ? alu : incPC) + (lng ? imm11 : imm8);
      br = t ? tgt : incPC;
      expLink = lsel ? incPC : br;
      expPC = sl ? incPC : (jump ? alu : br);
      #1;
      checkVal("newPC", newPC, expPC);
      tick();
      checkVal("exMem.link", exMem.link, expLink);
   endtask

   task automatic pcTest();
      int e;
      e = errCount;
      pcCase(16'h0000, isaPkg::brEqz, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      pcCase(16'h0000, isaPkg::brNez, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      // JAL, JR, JALR, SLBI
      pcCase(16'h0000, isaPkg::brGez, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
      pcCase(16'h0400, isaPkg::brGez, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      pcCase(16'h0480, isaPkg::brGez, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
      // taken condition so the fall-through differs from the target
      pcCase(16'h0480, isaPkg::brGez, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
      reportTest("nextpc", e);
   endtask

   task automatic stallTest();
      int e;
      e = errCount;
      @(negedge clk);
      setDefaults();
      ctrl.aluOp = isaPkg::aluOr;
      ctrl.isLoad = 1'b1;
      inA = 16'h00f0;
      inB = 16'h0f00;
      tick();
      checkVal("memValid", {15'h0, memValid}, 16'h1);
      checkVal("exMem.result", exMem.result, 16'h0ff0);
      checkVal("exMem.isLoad", {15'h0, exMem.isLoad}, 16'h1);
      // pending instruction waits behind the stall
      @(negedge clk);
      stall = 1'b1;
      exValid = 1'b0;
      ctrl.isLoad = 1'b0;
      inA = 16'h1234;
      repeat (3) tick();
      checkVal("exMem.result", exMem.result, 16'h0ff0);
      checkVal("exMem.isLoad", {15'h0, exMem.isLoad}, 16'h1);
      checkVal("memValid", {15'h0, memValid}, 16'h1);
      @(negedge clk);
      stall = 1'b0;
      tick();
      checkVal("exMem.result", exMem.result, 16'h1f34);
      checkVal("exMem.isLoad", {15'h0, exMem.isLoad}, 16'h0);
      checkVal("memValid", {15'h0, memValid}, 16'h0);
      reportTest("stall", e);
   endtask

   initial begin
      setDefaults();
      @(posedge arstN);
      #1;
      resetTest();
      aluTest();
      branchTest();
      forwardTest();
      pcTest();
      stallTest();
      $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/operandForward.sv
logic/alu.sv
logic/branchCond.sv
logic/pcTarget.sv
logic/executeStage.sv
tests/tbClock.sv
tests/executeStage_sva.sv
tests/executeStage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the log

verilator --binary --timing --assert -Wno-fatal --top-module executeStage_tb \
   -f build.f -o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
